/* all.f */
verilog/coder_pkg.sv
verilog/resolver_pkg.sv
verilog/carry_step.sv
verilog/stream_ctrl.sv
verilog/record_out.sv
verilog/carry_resolver.sv
bench/resolver_assert.sv
bench/resolver_checker.sv
bench/tb_carry_resolver.sv

/* bench/resolver_assert.sv */
// *********************************************************************
// Concurrent checks on the resolver input rules and the run counter
// Bound into carry_resolver, counts its own failures for the testbench
// *********************************************************************
`timescale 1ns/100ps

module resolver_assert (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic                   finish,
  input  coder_pkg::code_count_t code_count,
  input  resolver_pkg::run_len_t run,
  output int                     fail_count
);
  import coder_pkg::*;
  import resolver_pkg::*;

  int finish_fails, start_fails, count_fails, run_fails;

  assign fail_count = finish_fails + start_fails + count_fails + run_fails;

  finish_alone: assert property (@(posedge clk) disable iff (!rst_n)
    finish |-> code_count == 2'd0)
    else begin
      finish_fails++;
      $error("finish arrived together with codes");
    end

  start_alone: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> code_count == 2'd0)
    else begin
      start_fails++;
      $error("start arrived together with codes");
    end

  legal_count: assert property (@(posedge clk) disable iff (!rst_n)
    code_count != 2'd3)
    else begin
      count_fails++;
      $error("code_count of 3 is not legal");
    end

  // Counter would wrap on the next 0xFF
  run_limit: assert property (@(posedge clk) disable iff (!rst_n)
    run != RUN_LEN_MAX)
    else begin
      run_fails++;
      $error("0xFF run reached the counter limit");
    end

endmodule

/* bench/resolver_checker.sv */
// *********************************************************************
// Reference model of the carry rule and comparison of the DUT records
// Inputs and outputs are sampled at the rising edge
// Payload of an invalid slot is not compared
// *********************************************************************
`timescale 1ns/100ps

module resolver_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic                   finish,
  input  coder_pkg::code_count_t code_count,
  input  coder_pkg::code_t       code_a,
  input  coder_pkg::code_t       code_b,
  input  logic                   rec0_valid,
  input  logic                   rec1_valid,
  input  coder_pkg::byte_t       rec0_head,
  input  coder_pkg::byte_t       rec1_head,
  input  resolver_pkg::run_len_t rec0_run,
  input  resolver_pkg::run_len_t rec1_run,
  input  coder_pkg::byte_t       rec0_run_byte,
  input  coder_pkg::byte_t       rec1_run_byte,
  input  logic                   done,
  output int                     error_count,
  output int                     record_count
);
  import coder_pkg::*;
  import resolver_pkg::*;

  resolver_state_t m_state;
  byte_t           m_pending;
  run_len_t        m_run;

  // Expected outputs for the next edge, slot 0 first
  int       exp_n;
  logic     exp_done;
  byte_t    exp_head     [RECORD_SLOTS];
  run_len_t exp_run      [RECORD_SLOTS];
  byte_t    exp_run_byte [RECORD_SLOTS];

  task automatic push_record(input byte_t head, input run_len_t run, input byte_t run_byte);
    exp_head[exp_n]     = head;
    exp_run[exp_n]      = run;
    exp_run_byte[exp_n] = run_byte;
    exp_n++;
  endtask

  task automatic apply_code(input code_t c);
    logic  carry;
    byte_t b;
    carry = c[8];
    b     = c[7:0];
    if (m_state == RS_PRIME) begin
      m_pending = b;   // Carry of the first code is lost
      m_run     = 16'd0;
      m_state   = RS_ACTIVE;
    end else if (m_state == RS_ACTIVE) begin
      if (!carry && b == 8'hFF) begin
        m_run = m_run + 16'd1;
      end else begin
        push_record(m_pending + {7'd0, carry}, m_run, carry ? 8'h00 : 8'hFF);
        m_pending = b;
        m_run     = 16'd0;
      end
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] expv, input logic [15:0] act);
    if (expv !== act) begin
      $display("MISMATCH %s expected %h got %h", name, expv, act);
      error_count++;
    end
  endtask

  task automatic compare_outputs();
    check_value("rec0_valid", 16'(exp_n > 0), 16'(rec0_valid));
    check_value("rec1_valid", 16'(exp_n > 1), 16'(rec1_valid));
    check_value("done", 16'(exp_done), 16'(done));
    if (exp_n > 0 && rec0_valid) begin
      check_value("rec0_head", 16'(exp_head[0]), 16'(rec0_head));
      check_value("rec0_run", exp_run[0], rec0_run);
      check_value("rec0_run_byte", 16'(exp_run_byte[0]), 16'(rec0_run_byte));
      record_count++;
    end
    if (exp_n > 1 && rec1_valid) begin
      check_value("rec1_head", 16'(exp_head[1]), 16'(rec1_head));
      check_value("rec1_run", exp_run[1], rec1_run);
      check_value("rec1_run_byte", 16'(exp_run_byte[1]), 16'(rec1_run_byte));
      record_count++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      m_state   = RS_IDLE;
      m_pending = 8'h00;
      m_run     = 16'd0;
      exp_n     = 0;
      exp_done  = 1'b0;
    end else begin
      compare_outputs();
      exp_n    = 0;
      exp_done = finish;
      if (start) begin
        m_state = RS_PRIME;
        m_run   = 16'd0;
      end else if (code_count != 2'd0) begin
        apply_code(code_a);
        if (code_count == 2'd2) apply_code(code_b);
      end else if (finish) begin
        if (m_state == RS_ACTIVE) push_record(m_pending, m_run, 8'hFF);
        m_state = RS_IDLE;   // Empty stream closes silently
        m_run   = 16'd0;
      end
    end
  end

endmodule

/* bench/tb_carry_resolver.sv */
// *********************************************************************
// Testbench for the carry resolver with random code streams
// Inputs change on the falling edge, a fixed seed makes runs repeatable
// Each stream is opened by start and closed by finish
// *********************************************************************
`timescale 1ns/100ps

module tb_carry_resolver;
  import coder_pkg::*;
  import resolver_pkg::*;

  localparam int DONE_TIMEOUT = 50;   // Cycles

  logic        clk, rst_n, start, finish;
  code_count_t code_count;
  code_t       code_a, code_b;
  logic        rec0_valid, rec1_valid, done;
  byte_t       rec0_head, rec1_head, rec0_run_byte, rec1_run_byte;
  run_len_t    rec0_run, rec1_run;
  int          error_count, record_count, test_count, total_errors;
  logic [31:0] rng;
  logic        hung;

  carry_resolver carry_resolver_i (
    .clk (clk), .rst_n (rst_n), .start (start), .finish (finish),
    .code_count (code_count), .code_a (code_a), .code_b (code_b),
    .rec0_valid (rec0_valid), .rec1_valid (rec1_valid),
    .rec0_head (rec0_head), .rec1_head (rec1_head),
    .rec0_run (rec0_run), .rec1_run (rec1_run),
    .rec0_run_byte (rec0_run_byte), .rec1_run_byte (rec1_run_byte),
    .done (done)
  );

  resolver_checker check_i (
    .clk (clk), .rst_n (rst_n), .start (start), .finish (finish),
    .code_count (code_count), .code_a (code_a), .code_b (code_b),
    .rec0_valid (rec0_valid), .rec1_valid (rec1_valid),
    .rec0_head (rec0_head), .rec1_head (rec1_head),
    .rec0_run (rec0_run), .rec1_run (rec1_run),
    .rec0_run_byte (rec0_run_byte), .rec1_run_byte (rec1_run_byte),
    .done (done), .error_count (error_count), .record_count (record_count)
  );

  bind carry_resolver resolver_assert assert_i (
    .clk (clk), .rst_n (rst_n), .start (start), .finish (finish),
    .code_count (code_count), .run (cur_run), .fail_count ()
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic draw(output logic [31:0] r);
    rng = next_random(rng);
    r   = rng;
  endtask

  task automatic make_code(input int ff_pct, input int carry_pct, output code_t c);
    logic [31:0] r;
    byte_t       b;
    draw(r);
    b = r[7:0];
    if (b == 8'hFF) b = 8'hFE;   // 0xFF only when asked for
    if ((r[31:8] % 24'd100) < 24'(ff_pct)) b = 8'hFF;
    c = {(r[15:8] % 8'd100) < 8'(carry_pct), b};
  endtask

  task automatic run_test(input string name, input int cycles, input int ff_pct,
                          input int carry_pct, input int max_count, input logic open);
    logic [31:0] r;
    int          err_before, rec_before, waited;
    err_before = error_count;
    rec_before = record_count;
    if (hung) return;
    if (open) begin
      @(negedge clk) start = 1'b1;
      @(negedge clk) start = 1'b0;
    end
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      draw(r);
      code_count = (max_count == 1) ? 2'd1 : code_count_t'(r % 32'd3);
      make_code(ff_pct, carry_pct, code_a);
      make_code(ff_pct, carry_pct, code_b);
      if (open && i == 0) begin
        // First code of a stream carries, and that carry must vanish
        if (code_count == 2'd0) code_count = 2'd1;
        code_a[BYTE_WIDTH] = 1'b1;
      end
    end
    @(negedge clk) code_count = 2'd0;
    if (open) begin
      finish = 1'b1;
      @(negedge clk) finish = 1'b0;
      waited = 0;
      while (!done && waited < DONE_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (!done) begin
        $display("timeout: no done pulse after finish in test %s", name);
        hung = 1'b1;
      end
    end
    repeat (2) @(negedge clk);
    test_count++;
    $display("test %s cycles %0d  records %0d  errors %0d", name, cycles,
             record_count - rec_before, error_count - err_before);
  endtask

  // *******************************************************************
  // Test sequence
  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    finish = 1'b0;
    code_count = 2'd0;
    code_a = '0;
    code_b = '0;
    rng = 32'h3121e16d;
    hung = 1'b0;
    test_count = 0;
    repeat (10) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;

    run_test("no_start", 24, 20, 30, 2, 1'b0);   // Idle ignores codes
    run_test("single", 60, 0, 30, 1, 1'b1);
    run_test("ff_runs", 80, 70, 25, 1, 1'b1);
    run_test("dual", 120, 40, 25, 2, 1'b1);
    run_test("empty", 0, 0, 0, 2, 1'b1);         // finish right after start
    run_test("restart", 40, 50, 50, 2, 1'b1);

    repeat (3) @(negedge clk);
    total_errors = error_count + carry_resolver_i.assert_i.fail_count;
    $display("%0d tests, %0d records, %0d errors", test_count, record_count, total_errors);
    if (hung || total_errors != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST OK");
    end
    $finish;
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the carry resolver testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
  --top-module tb_carry_resolver -f all.f

# Keep running after an assertion so the testbench can report
./obj_dir/Vtb_carry_resolver +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation passed"

/* verilog/carry_resolver.sv */
// *********************************************************************
// Carry propagation stage of the arithmetic encoder
// Up to two 9 bit codes per cycle, records one cycle after the codes
// start and finish must arrive in cycles with a code count of 0
// code_a is used for counts 1 and 2, code_b only for a count of 2
// The first carry after start is dropped
// *********************************************************************
`timescale 1ns/100ps

module carry_resolver (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic                     finish,
  input  coder_pkg::code_count_t   code_count,
  input  coder_pkg::code_t         code_a,
  input  coder_pkg::code_t         code_b,
  output logic                     rec0_valid,
  output logic                     rec1_valid,
  output coder_pkg::byte_t         rec0_head,
  output coder_pkg::byte_t         rec1_head,
  output resolver_pkg::run_len_t   rec0_run,
  output resolver_pkg::run_len_t   rec1_run,
  output coder_pkg::byte_t         rec0_run_byte,
  output coder_pkg::byte_t         rec1_run_byte,
  output logic                     done
);
  import coder_pkg::*;
  import resolver_pkg::*;

  // Registered state, after step a, after step b
  resolver_state_t cur_state, mid_state, next_state;
  byte_t           cur_pending, mid_pending, next_pending;
  run_len_t        cur_run, mid_run, next_run;

  logic     a_code_valid, b_code_valid;
  logic     a_valid, b_valid;
  byte_t    a_head, b_head;
  run_len_t a_run, b_run;
  byte_t    a_run_byte, b_run_byte;

  assign a_code_valid = (code_count != 2'd0);
  assign b_code_valid = (code_count == 2'd2);

  stream_ctrl ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .next_state   (next_state),
    .next_pending (next_pending),
    .next_run     (next_run),
    .state        (cur_state),
    .pending      (cur_pending),
    .run          (cur_run)
  );

  // *******************************************************************
  // Two chained steps, code_a first
  carry_step step_a (
    .state_in     (cur_state),
    .pending_in   (cur_pending),
    .run_in       (cur_run),
    .code         (code_a),
    .code_valid   (a_code_valid),
    .flush        (finish),
    .state_out    (mid_state),
    .pending_out  (mid_pending),
    .run_out      (mid_run),
    .rec_valid    (a_valid),
    .rec_head     (a_head),
    .rec_run      (a_run),
    .rec_run_byte (a_run_byte)
  );

  carry_step step_b (
    .state_in     (mid_state),
    .pending_in   (mid_pending),
    .run_in       (mid_run),
    .code         (code_b),
    .code_valid   (b_code_valid),
    .flush        (1'b0),           // finish is handled by step a
    .state_out    (next_state),
    .pending_out  (next_pending),
    .run_out      (next_run),
    .rec_valid    (b_valid),
    .rec_head     (b_head),
    .rec_run      (b_run),
    .rec_run_byte (b_run_byte)
  );

  record_out out_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .finish        (finish),
    .a_valid       (a_valid),
    .a_head        (a_head),
    .a_run         (a_run),
    .a_run_byte    (a_run_byte),
    .b_valid       (b_valid),
    .b_head        (b_head),
    .b_run         (b_run),
    .b_run_byte    (b_run_byte),
    .rec0_valid    (rec0_valid),
    .rec0_head     (rec0_head),
    .rec0_run      (rec0_run),
    .rec0_run_byte (rec0_run_byte),
    .rec1_valid    (rec1_valid),
    .rec1_head     (rec1_head),
    .rec1_run      (rec1_run),
    .rec1_run_byte (rec1_run_byte),
    .done          (done)
  );

endmodule

/* verilog/carry_step.sv */
// *********************************************************************
// Resolves one code against the pending byte and its 0xFF run
// Purely combinational, two copies are chained for two codes per cycle
// A flush request is only honoured when no code is valid
// The run counter wraps silently on overflow
// *********************************************************************
`timescale 1ns/100ps

module carry_step (
  input  resolver_pkg::resolver_state_t state_in,
  input  coder_pkg::byte_t              pending_in,
  input  resolver_pkg::run_len_t        run_in,
  input  coder_pkg::code_t              code,
  input  logic                          code_valid,
  input  logic                          flush,
  output resolver_pkg::resolver_state_t state_out,
  output coder_pkg::byte_t              pending_out,
  output resolver_pkg::run_len_t        run_out,
  output logic                          rec_valid,
  output coder_pkg::byte_t              rec_head,
  output resolver_pkg::run_len_t        rec_run,
  output coder_pkg::byte_t              rec_run_byte
);
  import coder_pkg::*;
  import resolver_pkg::*;

  logic  code_carry;
  byte_t code_byte;
  logic  code_closes;   // Code ends the current run

  assign code_carry  = code[BYTE_WIDTH];
  assign code_byte   = code[BYTE_WIDTH-1:0];
  assign code_closes = code_carry || (code_byte != BYTE_ALL_ONES);

  always_comb begin
    // Pass through unless a code or flush acts
    state_out    = state_in;
    pending_out  = pending_in;
    run_out      = run_in;
    rec_valid    = 1'b0;
    rec_head     = pending_in;
    rec_run      = run_in;
    rec_run_byte = BYTE_ALL_ONES;

    case (state_in)
      // *************************************************************
      RS_PRIME: begin
        if (code_valid) begin
          // First carry has no earlier byte to land on
          state_out   = RS_ACTIVE;
          pending_out = code_byte;
          run_out     = '0;
        end else if (flush) begin
          state_out = RS_IDLE;   // Empty stream ends without a record
        end
      end

      // *************************************************************
      RS_ACTIVE: begin
        if (code_valid) begin
          if (code_closes) begin
            rec_valid    = 1'b1;
            rec_head     = pending_in + byte_t'(code_carry);
            rec_run_byte = BYTE_ALL_ONES + byte_t'(code_carry);   // 0xFF or 0x00
            pending_out  = code_byte;
            run_out      = '0;
          end else begin
            run_out = run_in + run_len_t'(1);   // Plain 0xFF
          end
        end else if (flush) begin
          // Final record keeps pending byte and run as they are
          rec_valid = 1'b1;
          state_out = RS_IDLE;
          run_out   = '0;
        end
      end

      // Idle ignores codes and flush
      default: begin
        state_out = state_in;
      end
    endcase
  end

endmodule

/* verilog/coder_pkg.sv */
// *********************************************************************
// Code and byte formats shared by the encoder stages
// A code is one carry bit placed directly above one output byte
// The carry belongs to bytes emitted earlier and never to its own byte
// At most two codes are presented per cycle
// *********************************************************************
package coder_pkg;

  localparam int BYTE_WIDTH = 8;
  localparam int CODE_WIDTH = BYTE_WIDTH + 1;   // Carry on top

  // One output byte of the coder
  typedef logic [BYTE_WIDTH-1:0] byte_t;

  // Input code laid out as {carry, byte}
  typedef logic [CODE_WIDTH-1:0] code_t;

  // Codes valid this cycle, 3 is not a legal count
  typedef logic [1:0] code_count_t;

  // Byte value that opens or lengthens a run
  localparam byte_t BYTE_ALL_ONES = 8'hFF;

endpackage

/* verilog/record_out.sv */
// *********************************************************************
// Packs up to two records and registers them for one cycle
// A lone record always appears in slot 0
// No back-pressure, the receiver takes every valid record at once
// Payload outputs hold their last value while the valid is low
// *********************************************************************
`timescale 1ns/100ps

module record_out (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   finish,
  input  logic                   a_valid,
  input  coder_pkg::byte_t       a_head,
  input  resolver_pkg::run_len_t a_run,
  input  coder_pkg::byte_t       a_run_byte,
  input  logic                   b_valid,
  input  coder_pkg::byte_t       b_head,
  input  resolver_pkg::run_len_t b_run,
  input  coder_pkg::byte_t       b_run_byte,
  output logic                   rec0_valid,
  output coder_pkg::byte_t       rec0_head,
  output resolver_pkg::run_len_t rec0_run,
  output coder_pkg::byte_t       rec0_run_byte,
  output logic                   rec1_valid,
  output coder_pkg::byte_t       rec1_head,
  output resolver_pkg::run_len_t rec1_run,
  output coder_pkg::byte_t       rec1_run_byte,
  output logic                   done
);
  import coder_pkg::*;
  import resolver_pkg::*;

  // Packed slots ahead of the registers
  logic     slot_valid    [RECORD_SLOTS];
  byte_t    slot_head     [RECORD_SLOTS];
  run_len_t slot_run      [RECORD_SLOTS];
  byte_t    slot_run_byte [RECORD_SLOTS];

  // Registered slots
  logic     out_valid     [RECORD_SLOTS];
  byte_t    out_head      [RECORD_SLOTS];
  run_len_t out_run       [RECORD_SLOTS];
  byte_t    out_run_byte  [RECORD_SLOTS];

  // Step b moves down to slot 0 when step a is silent
  always_comb begin
    slot_valid[0]    = a_valid || b_valid;
    slot_head[0]     = a_valid ? a_head : b_head;
    slot_run[0]      = a_valid ? a_run : b_run;
    slot_run_byte[0] = a_valid ? a_run_byte : b_run_byte;
    slot_valid[1]    = a_valid && b_valid;
    slot_head[1]     = b_head;
    slot_run[1]      = b_run;
    slot_run_byte[1] = b_run_byte;
  end

  // *******************************************************************
  // Valids and done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < RECORD_SLOTS; i++) begin
        out_valid[i] <= 1'b0;
      end
      done <= 1'b0;
    end else begin
      for (int i = 0; i < RECORD_SLOTS; i++) begin
        out_valid[i] <= slot_valid[i];
      end
      done <= finish;   // Final record lands in the same cycle
    end
  end

  // Payload loads only with a record
  always_ff @(posedge clk) begin
    for (int i = 0; i < RECORD_SLOTS; i++) begin
      if (slot_valid[i]) begin
        out_head[i]     <= slot_head[i];
        out_run[i]      <= slot_run[i];
        out_run_byte[i] <= slot_run_byte[i];
      end
    end
  end

  assign rec0_valid    = out_valid[0];
  assign rec0_head     = out_head[0];
  assign rec0_run      = out_run[0];
  assign rec0_run_byte = out_run_byte[0];
  assign rec1_valid    = out_valid[1];
  assign rec1_head     = out_head[1];
  assign rec1_run      = out_run[1];
  assign rec1_run_byte = out_run_byte[1];

endmodule

/* verilog/resolver_pkg.sv */
// *********************************************************************
// Types and constants of the carry resolver
// The run counter has no saturation and must stay below RUN_LEN_MAX
// Up to RECORD_SLOTS records leave the resolver per cycle
// *********************************************************************
package resolver_pkg;

  localparam int RUN_LEN_WIDTH = 16;

  // Length of the pending 0xFF run
  typedef logic [RUN_LEN_WIDTH-1:0] run_len_t;

  // Reaching this count is an error in the stream
  localparam run_len_t RUN_LEN_MAX = '1;

  // Resolver FSM
  typedef enum logic [1:0] {
    RS_IDLE   = 2'd0,   // No stream open
    RS_PRIME  = 2'd1,   // Waiting for the first code
    RS_ACTIVE = 2'd2    // Pending byte held
  } resolver_state_t;

  localparam int RECORD_SLOTS = 2;

endpackage

/* verilog/stream_ctrl.sv */
// *********************************************************************
// Resolver FSM plus the pending byte and run registers
// start overrides the computed next values and opens a fresh stream
// start must not coincide with codes or they are lost
// *********************************************************************
`timescale 1ns/100ps

module stream_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  resolver_pkg::resolver_state_t next_state,
  input  coder_pkg::byte_t              next_pending,
  input  resolver_pkg::run_len_t        next_run,
  output resolver_pkg::resolver_state_t state,
  output coder_pkg::byte_t              pending,
  output resolver_pkg::run_len_t        run
);
  import coder_pkg::*;
  import resolver_pkg::*;

  // *******************************************************************
  // FSM state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RS_IDLE;
    end else if (start) begin
      state <= RS_PRIME;   // Drops any open stream
    end else begin
      state <= next_state;
    end
  end

  // *******************************************************************
  // Pending byte and run length
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= byte_t'(0);
      run     <= '0;
    end else if (start) begin
      pending <= byte_t'(0);
      run     <= '0;   // No run carried into the new stream
    end else begin
      pending <= next_pending;
      run     <= next_run;
    end
  end

endmodule
